// ==== Makefile ====
TOP = tb_input_queue_controller

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f list.f -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee run.log
	grep -q "All tests passed!" run.log

clean:
	rm -rf obj_dir run.log

// ==== bench/iqc_checker.sv ====
`timescale 1ns/1ps

module iqc_checker import iqc_pkg::*; #(
  parameter int queue_id = default_queue_id,
  parameter int addr_width = default_addr_width,
  parameter int qtd_width = default_qtd_width,
  parameter int data_width = default_data_width,
  parameter int tag_width = default_tag_width
) (
  input  logic                            clk,
  input  logic                            rst_internal,
  input  logic                            start,
  input  logic                            available_read,
  input  logic                            request_read,
  input  logic [addr_width+tag_width-1:0] request_data,
  input  logic                            read_data_valid,
  input  logic [tag_width-1:0]            read_queue_id,
  input  logic                            acc_user_request_read,
  input  logic                            acc_user_available_read,
  input  logic [data_width-1:0]           acc_user_read_data,
  input  logic                            acc_user_read_data_valid,
  input  logic                            has_rd_pending,
  input  logic                            done,
  input  logic [addr_width-1:0]           exp_base,
  input  logic [qtd_width-1:0]            exp_total,
  input  logic                            exp_active,
  input  int                              test_id,
  input  logic                            test_end,
  output int                              lines_seen,
  output int                              errors,
  output int                              tests_failed
);

  int req_count = 0;
  int line_count = 0;
  int own_count = 0;
  int user_reads = 0;
  int test_errors = 0;
  int error_count = 0;
  int failed_count = 0;
  logic user_d1 = 1'b0;
  logic user_d2 = 1'b0;
  logic prev_avail = 1'b0;
  logic prev_start = 1'b0;
  logic [addr_width-1:0] want_addr;
  logic [data_width-1:0] want_data;

  assign lines_seen = line_count;
  assign errors = error_count;
  assign tests_failed = failed_count;

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    test_errors++;
    error_count++;
  endtask

  always @(posedge clk) begin
    if (rst_internal) begin
      req_count = 0;
      line_count = 0;
      own_count = 0;
      user_reads = 0;
      test_errors = 0;
      user_d1 = 1'b0;
      user_d2 = 1'b0;
      prev_avail = 1'b0;
      prev_start = 1'b0;
    end else begin
      if (request_read) begin
        want_addr = exp_base + addr_width'(req_count * lines_per_request);
        if (!prev_avail)
          report_error("request_read without available_read in the previous cycle");
        if (request_data[addr_width+tag_width-1:tag_width] != want_addr)
          report_error($sformatf("request %0d address %h, expected %h", req_count,
                                 request_data[addr_width+tag_width-1:tag_width], want_addr));
        if (request_data[tag_width-1:0] != tag_width'(queue_id))
          report_error($sformatf("request %0d tag %0d, expected %0d", req_count,
                                 request_data[tag_width-1:0], queue_id));
        req_count++;
      end
      // user data follows the user read by two cycles.
      if (acc_user_read_data_valid != user_d2)
        report_error($sformatf("user data valid %b, expected %b", acc_user_read_data_valid,
                               user_d2));
      if (acc_user_read_data_valid) begin
        want_data = data_width'(exp_base + addr_width'(line_count));
        if (acc_user_read_data != want_data)
          report_error($sformatf("line %0d data %h, expected %h", line_count,
                                 acc_user_read_data, want_data));
        line_count++;
      end
      if (done && (!prev_start || !exp_active || own_count < int'(exp_total)))
        report_error("done high before all lines arrived or without start");
      // the user port may only offer a line that has already arrived.
      if (acc_user_available_read && own_count <= user_reads)
        report_error($sformatf("user port available with %0d lines in and %0d read",
                               own_count, user_reads));
      if (acc_user_request_read)
        user_reads++;
      if (read_data_valid && read_queue_id == tag_width'(queue_id))
        own_count++;
      if (test_end) begin
        if (exp_active) begin
          if (req_count != int'(exp_total) / lines_per_request)
            report_error($sformatf("%0d requests, expected %0d", req_count,
                                   int'(exp_total) / lines_per_request));
          if (line_count != int'(exp_total))
            report_error($sformatf("%0d user lines, expected %0d", line_count, exp_total));
          if (!done)
            report_error("done low at the end of the test");
        end else begin
          if (req_count != 0 || line_count != 0)
            report_error($sformatf("%0d requests and %0d lines from an ignored word",
                                   req_count, line_count));
          if (done)
            report_error("done high for an ignored configuration");
        end
        if (has_rd_pending)
          report_error("has_rd_pending high after all responses returned");
        if (test_errors > 0)
          failed_count++;
        $display("test %0d: %0d requests, %0d lines, %s", test_id, req_count, line_count,
                 (test_errors == 0) ? "passed" : "failed");
      end
      user_d2 = user_d1;
      user_d1 = acc_user_request_read;
      prev_avail = available_read;
      prev_start = start;
    end
  end

endmodule

// ==== bench/tb_input_queue_controller.sv ====
`timescale 1ns/1ps

module tb_input_queue_controller;

  localparam int queue_id = 3;
  localparam int num_tests = 6;

  typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  id;
    logic [31:0] base;
    logic [15:0] total;
    logic [7:0]  backpressure;
    logic        foreign;
    logic        active;
  } test_row_t;

  // kind, id, base, line total, back-pressure percent, foreign tags, requests expected.
  test_row_t rows [num_tests] = '{
    '{2'd1, 8'd3, 32'h0000_1000, 16'd16, 8'd0, 1'b0, 1'b1},
    '{2'd1, 8'd3, 32'h0002_0040, 16'd32, 8'd30, 1'b1, 1'b1},
    '{2'd1, 8'd5, 32'h0000_3000, 16'd8, 8'd0, 1'b0, 1'b0},
    '{2'd2, 8'd3, 32'h0000_4000, 16'd8, 8'd0, 1'b0, 1'b0},
    '{2'd1, 8'd3, 32'h8000_0100, 16'd96, 8'd50, 1'b1, 1'b1},
    '{2'd1, 8'd3, 32'h00ff_fff0, 16'd4, 8'd70, 1'b1, 1'b1}
  };

  logic clk = 1'b0;
  logic rst_internal = 1'b1;
  logic start = 1'b0;
  logic [1:0] conf_valid = 2'd0;
  logic [55:0] conf = '0;
  logic available_read = 1'b0;
  logic read_data_valid = 1'b0;
  logic [7:0] read_queue_id = '0;
  logic [31:0] read_data = '0;
  logic acc_user_request_read = 1'b0;
  logic has_rd_pending;
  logic request_read;
  logic [39:0] request_data;
  logic acc_user_available_read;
  logic [31:0] acc_user_read_data;
  logic acc_user_read_data_valid;
  logic done;

  logic [31:0] exp_base = '0;
  logic [15:0] exp_total = '0;
  logic exp_active = 1'b0;
  logic test_end = 1'b0;
  int test_id = 0;
  logic [7:0] row_bp = '0;
  logic row_foreign = 1'b0;
  int lines_seen;
  int errors;
  int tests_failed;

  logic in_reset = 1'b1;
  logic [31:0] line_q [$];
  logic [31:0] rng = 32'd70332;
  int pick;

  always #50 clk = ~clk;

  input_queue_controller #(.queue_id(queue_id)) input_queue_controller_i (
    .clk(clk),
    .rst_internal(rst_internal),
    .start(start),
    .conf_valid(conf_valid),
    .conf(conf),
    .available_read(available_read),
    .has_rd_pending(has_rd_pending),
    .request_read(request_read),
    .request_data(request_data),
    .read_data_valid(read_data_valid),
    .read_queue_id(read_queue_id),
    .read_data(read_data),
    .acc_user_available_read(acc_user_available_read),
    .acc_user_request_read(acc_user_request_read),
    .acc_user_read_data(acc_user_read_data),
    .acc_user_read_data_valid(acc_user_read_data_valid),
    .done(done)
  );

  iqc_checker #(.queue_id(queue_id)) checker_i (
    .clk(clk), .rst_internal(rst_internal), .start(start),
    .available_read(available_read), .request_read(request_read),
    .request_data(request_data), .read_data_valid(read_data_valid),
    .read_queue_id(read_queue_id), .acc_user_request_read(acc_user_request_read),
    .acc_user_available_read(acc_user_available_read),
    .acc_user_read_data(acc_user_read_data),
    .acc_user_read_data_valid(acc_user_read_data_valid),
    .has_rd_pending(has_rd_pending), .done(done), .exp_base(exp_base),
    .exp_total(exp_total), .exp_active(exp_active), .test_id(test_id),
    .test_end(test_end), .lines_seen(lines_seen), .errors(errors),
    .tests_failed(tests_failed)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  always @(posedge clk) in_reset = rst_internal;

  // memory port model and user reader share one random stream.
  always @(negedge clk) begin
    if (in_reset) begin
      line_q.delete();
      available_read = 1'b0;
      read_data_valid = 1'b0;
      acc_user_request_read = 1'b0;
    end else begin
      if (request_read) begin
        for (int k = 0; k < 4; k++) begin
          line_q.push_back(request_data[39:8] + 32'(k));
        end
      end
      rng = xorshift(rng);
      available_read = int'(rng % 32'd100) >= int'(row_bp);
      rng = xorshift(rng);
      pick = int'(rng % 32'd100);
      read_data_valid = 1'b0;
      if (row_foreign && pick < 25) begin
        // a response meant for another queue.
        read_data_valid = 1'b1;
        read_queue_id = 8'(queue_id + 2);
        read_data = rng;
      end else if (line_q.size() > 0 && pick < 75) begin
        read_data_valid = 1'b1;
        read_queue_id = 8'(queue_id);
        read_data = line_q.pop_front();
      end
      rng = xorshift(rng);
      acc_user_request_read = acc_user_available_read && (rng[3:0] < 4'd10);
    end
  end

  initial begin
    int limit;
    limit = num_tests * 200;
    foreach (rows[i]) limit += int'(rows[i].total) * 40;
    repeat (limit) @(posedge clk);
    $display("timeout: the tests did not finish within %0d cycles", limit);
    $display("Test failures found");
    $finish;
  end

  initial begin
    for (int t = 0; t < num_tests; t++) begin
      @(negedge clk);
      rst_internal = 1'b1;
      start = 1'b0;
      @(negedge clk);
      // row settings change only while the memory model is held in reset.
      test_id = t;
      row_bp = rows[t].backpressure;
      row_foreign = rows[t].foreign;
      exp_base = rows[t].base;
      exp_total = rows[t].total;
      exp_active = rows[t].active;
      repeat (2) @(negedge clk);
      rst_internal = 1'b0;
      conf_valid = rows[t].kind;
      conf = {rows[t].base, rows[t].total, rows[t].id};
      @(negedge clk);
      conf_valid = 2'd0;
      conf = '0;
      repeat (4) @(negedge clk);
      start = 1'b1;
      if (rows[t].active) begin
        while (lines_seen < int'(rows[t].total)) @(negedge clk);
        while (!done) @(negedge clk);
        repeat (3) @(negedge clk);
        // done must drop with start and come back with it.
        start = 1'b0;
        repeat (4) @(negedge clk);
        start = 1'b1;
        while (!done) @(negedge clk);
      end else begin
        repeat (40) @(negedge clk);
      end
      test_end = 1'b1;
      @(negedge clk);
      test_end = 1'b0;
    end
    @(negedge clk);
    $display("%0d tests run, %0d failed, %0d errors", num_tests, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
src/iqc_pkg.sv
src/conf_decoder.sv
src/read_requester.sv
src/line_buffer.sv
src/input_queue_controller.sv
bench/iqc_checker.sv
bench/tb_input_queue_controller.sv

// ==== src/conf_decoder.sv ====
`timescale 1ns/1ps

module conf_decoder import iqc_pkg::*; #(
  parameter int queue_id = default_queue_id,
  parameter int addr_width = default_addr_width,
  parameter int qtd_width = default_qtd_width,
  parameter int id_width = default_id_width
) (
  input  logic                                    clk,
  input  logic                                    rst_internal,
  input  logic [1:0]                              conf_valid,
  input  logic [addr_width+qtd_width+id_width-1:0] conf,
  output logic                                    conf_ready,
  output logic [addr_width-1:0]                   base_addr,
  output logic [qtd_width-1:0]                    line_total
);

  logic accept;

  // word layout is {address, quantity, id}.
  assign accept = (conf_valid == conf_kind_input) &&
                  (conf[id_width-1:0] == id_width'(queue_id));

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      conf_ready <= 1'b0;
      base_addr <= '0;
      line_total <= '0;
    end else begin
      if (accept) begin
        conf_ready <= 1'b1;
        line_total <= conf[id_width +: qtd_width];
        base_addr <= conf[id_width+qtd_width +: addr_width];
      end
    end
  end

  // once configured the queue stays configured until the next reset.
  conf_ready_sticky: assert property (
    @(posedge clk) $fell(conf_ready) |-> $past(rst_internal)
  ) else $error("conf_ready dropped without reset.");

endmodule

// ==== src/input_queue_controller.sv ====
`timescale 1ns/1ps

module input_queue_controller import iqc_pkg::*; #(
  parameter int queue_id = default_queue_id,
  parameter int addr_width = default_addr_width,
  parameter int qtd_width = default_qtd_width,
  parameter int data_width = default_data_width,
  parameter int id_width = default_id_width,
  parameter int tag_width = default_tag_width
) (
  input  logic                                     clk,
  input  logic                                     rst_internal,
  input  logic                                     start,
  input  logic [1:0]                               conf_valid,
  input  logic [addr_width+qtd_width+id_width-1:0] conf,
  input  logic                                     available_read,
  output logic                                     has_rd_pending,
  output logic                                     request_read,
  output logic [addr_width+tag_width-1:0]          request_data,
  input  logic                                     read_data_valid,
  input  logic [tag_width-1:0]                     read_queue_id,
  input  logic [data_width-1:0]                    read_data,
  output logic                                     acc_user_available_read,
  input  logic                                     acc_user_request_read,
  output logic [data_width-1:0]                    acc_user_read_data,
  output logic                                     acc_user_read_data_valid,
  output logic                                     done
);

  logic                  conf_ready;
  logic [addr_width-1:0] base_addr;
  logic [qtd_width-1:0]  line_total;
  logic                  tagged_valid;

  conf_decoder #(
    .queue_id(queue_id),
    .addr_width(addr_width),
    .qtd_width(qtd_width),
    .id_width(id_width)
  ) conf_decoder_i (
    .clk(clk),
    .rst_internal(rst_internal),
    .conf_valid(conf_valid),
    .conf(conf),
    .conf_ready(conf_ready),
    .base_addr(base_addr),
    .line_total(line_total)
  );

  read_requester #(
    .queue_id(queue_id),
    .addr_width(addr_width),
    .qtd_width(qtd_width),
    .tag_width(tag_width)
  ) read_requester_i (
    .clk(clk),
    .rst_internal(rst_internal),
    .start(start),
    .conf_ready(conf_ready),
    .base_addr(base_addr),
    .line_total(line_total),
    .available_read(available_read),
    .user_read(acc_user_request_read),
    .tagged_valid(tagged_valid),
    .request_read(request_read),
    .request_data(request_data),
    .has_rd_pending(has_rd_pending)
  );

  line_buffer #(
    .queue_id(queue_id),
    .qtd_width(qtd_width),
    .data_width(data_width),
    .tag_width(tag_width)
  ) line_buffer_i (
    .clk(clk),
    .rst_internal(rst_internal),
    .start(start),
    .line_total(line_total),
    .read_data_valid(read_data_valid),
    .read_queue_id(read_queue_id),
    .read_data(read_data),
    .acc_user_request_read(acc_user_request_read),
    .acc_user_available_read(acc_user_available_read),
    .acc_user_read_data(acc_user_read_data),
    .acc_user_read_data_valid(acc_user_read_data_valid),
    .tagged_valid(tagged_valid),
    .done(done)
  );

endmodule

// ==== src/iqc_pkg.sv ====
package iqc_pkg;

  // default widths that the top level overrides.
  localparam int default_queue_id = 3;
  localparam int default_addr_width = 32;
  localparam int default_qtd_width = 16;
  localparam int default_data_width = 32;
  localparam int default_id_width = 8;
  localparam int default_tag_width = 8;

  // configuration kind carried on conf_valid for an input queue.
  localparam logic [1:0] conf_kind_input = 2'd1;

  // lines fetched by one read request and the address step.
  localparam int lines_per_request = 4;

  // line buffer holds 2**buffer_depth_bits entries.
  localparam int buffer_depth_bits = 6;

  // free entries kept in reserve before a new request may go out.
  localparam int fit_margin = 8;

  // below this fill level the user port only offers data every other cycle.
  localparam int almost_empty_level = 2;

endpackage

// ==== src/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer import iqc_pkg::*; #(
  parameter int queue_id = default_queue_id,
  parameter int qtd_width = default_qtd_width,
  parameter int data_width = default_data_width,
  parameter int tag_width = default_tag_width
) (
  input  logic                  clk,
  input  logic                  rst_internal,
  input  logic                  start,
  input  logic [qtd_width-1:0]  line_total,
  input  logic                  read_data_valid,
  input  logic [tag_width-1:0]  read_queue_id,
  input  logic [data_width-1:0] read_data,
  input  logic                  acc_user_request_read,
  output logic                  acc_user_available_read,
  output logic [data_width-1:0] acc_user_read_data,
  output logic                  acc_user_read_data_valid,
  output logic                  tagged_valid,
  output logic                  done
);

  localparam int buffer_depth = 1 << buffer_depth_bits;

  logic [data_width-1:0]        mem [buffer_depth];
  logic [buffer_depth_bits-1:0] wr_ptr;
  logic [buffer_depth_bits-1:0] rd_ptr;
  logic [buffer_depth_bits:0]   fill;
  logic                         wr_en;
  logic [data_width-1:0]        wr_data;
  logic [qtd_width-1:0]         rx_count;
  logic                         rd_stage_valid;
  logic [data_width-1:0]        rd_stage_data;
  logic                         buffer_empty;

  assign tagged_valid = read_data_valid && (read_queue_id == tag_width'(queue_id));
  assign buffer_empty = fill == '0;
  // near empty the port skips a cycle after each read so the fill count can catch up.
  assign acc_user_available_read = (fill >= almost_empty_level) ? 1'b1 :
                                   (!buffer_empty && !rd_stage_valid);

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      wr_en <= 1'b0;
      rx_count <= '0;
      done <= 1'b0;
    end else begin
      wr_en <= tagged_valid;
      if (tagged_valid) begin
        rx_count <= rx_count + 1'b1;
      end
      // a zero total means the queue was never configured.
      done <= start && (line_total != '0) && (rx_count >= line_total);
    end
  end

  always_ff @(posedge clk) begin
    if (tagged_valid) begin
      wr_data <= read_data;
    end
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
    if (acc_user_request_read) begin
      rd_stage_data <= mem[rd_ptr];
    end
    acc_user_read_data <= rd_stage_data;
  end

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
      rd_stage_valid <= 1'b0;
      acc_user_read_data_valid <= 1'b0;
    end else begin
      rd_stage_valid <= acc_user_request_read;
      acc_user_read_data_valid <= rd_stage_valid;
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (acc_user_request_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, acc_user_request_read})
        2'b10: fill <= fill + 1'b1;
        2'b01: fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // the requester's fit check must keep the buffer from overflowing.
  no_write_when_full: assert property (
    @(posedge clk) disable iff (rst_internal) wr_en |-> (fill < buffer_depth)
  ) else $error("line buffer written while full.");

endmodule

// ==== src/read_requester.sv ====
`timescale 1ns/1ps

module read_requester import iqc_pkg::*; #(
  parameter int queue_id = default_queue_id,
  parameter int addr_width = default_addr_width,
  parameter int qtd_width = default_qtd_width,
  parameter int tag_width = default_tag_width
) (
  input  logic                            clk,
  input  logic                            rst_internal,
  input  logic                            start,
  input  logic                            conf_ready,
  input  logic [addr_width-1:0]           base_addr,
  input  logic [qtd_width-1:0]            line_total,
  input  logic                            available_read,
  input  logic                            user_read,
  input  logic                            tagged_valid,
  output logic                            request_read,
  output logic [addr_width+tag_width-1:0] request_data,
  output logic                            has_rd_pending
);

  localparam int buffer_depth = 1 << buffer_depth_bits;
  localparam logic [addr_width-1:0] addr_step = addr_width'(lines_per_request);
  localparam logic [qtd_width-1:0] group_lines = qtd_width'(lines_per_request);
  localparam logic [qtd_width-1:0] lookahead = qtd_width'(2 * lines_per_request);
  localparam logic [buffer_depth_bits:0] pend_step = (buffer_depth_bits + 1)'(lines_per_request);
  localparam logic [buffer_depth_bits:0] fit_limit =
    (buffer_depth_bits + 1)'(buffer_depth - fit_margin);

  logic [addr_width-1:0]      addr_next;
  logic                       addr_loaded;
  logic [qtd_width-1:0]       count_req;
  logic                       issue_req;
  logic                       issue_req_next;
  logic [buffer_depth_bits:0] pending_user;
  logic [buffer_depth_bits:0] pending_resp;
  logic                       more_lines;
  logic                       more_lines_next;
  logic                       buffer_fit;
  logic                       fire;

  assign more_lines = count_req < line_total;
  // the count lags the issue flag by one group, so look two groups ahead.
  assign more_lines_next = (count_req + lookahead) < line_total;
  assign buffer_fit = pending_user < fit_limit;
  assign fire = issue_req && available_read && buffer_fit;

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      addr_loaded <= 1'b0;
    end else if (conf_ready) begin
      addr_loaded <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (conf_ready && !addr_loaded) begin
      addr_next <= base_addr;
    end else if (fire) begin
      addr_next <= addr_next + addr_step;
    end
    if (fire) begin
      request_data <= {addr_next, tag_width'(queue_id)};
    end
  end

  always_ff @(posedge clk) begin
    if (rst_internal) begin
      request_read <= 1'b0;
      count_req <= '0;
      issue_req <= 1'b0;
      issue_req_next <= 1'b0;
    end else begin
      issue_req <= start && conf_ready && addr_loaded && more_lines &&
                   available_read && buffer_fit;
      issue_req_next <= start && conf_ready && addr_loaded && more_lines_next &&
                        available_read && buffer_fit;
      request_read <= fire;
      if (fire) begin
        count_req <= count_req + group_lines;
        issue_req <= issue_req_next;
      end
    end
  end

  // lines requested and not yet taken by the user bound the buffer fill.
  always_ff @(posedge clk) begin
    if (rst_internal) begin
      pending_user <= '0;
      pending_resp <= '0;
      has_rd_pending <= 1'b0;
    end else begin
      case ({user_read, fire})
        2'b01: pending_user <= pending_user + pend_step;
        2'b10: pending_user <= pending_user - 1'b1;
        2'b11: pending_user <= pending_user + pend_step - 1'b1;
        default: pending_user <= pending_user;
      endcase
      case ({tagged_valid, fire})
        2'b01: pending_resp <= pending_resp + pend_step;
        2'b10: pending_resp <= pending_resp - 1'b1;
        2'b11: pending_resp <= pending_resp + pend_step - 1'b1;
        default: pending_resp <= pending_resp;
      endcase
      has_rd_pending <= pending_resp != '0;
    end
  end

  request_needs_available: assert property (
    @(posedge clk) disable iff (rst_internal) request_read |-> $past(available_read)
  ) else $error("request_read issued without available_read in the previous cycle.");

endmodule
